// File: rvfi_bitmanip_macros.svh
`ifndef RVFI_BITMANIP_MACROS_SVH
`define RVFI_BITMANIP_MACROS_SVH

// number of spec lanes, keep a power of two so the turn pointers wrap
`define RVB_NUM_LANES 4

// width of a lane index
`define RVB_LANE_W 2

// one bit per compared field, see rvb_field_e
`define RVB_MISMATCH_W 6

`endif

// File: rvfi_bitmanip_pkg.sv
`default_nettype none

`include "rvfi_bitmanip_macros.svh"

package rvfi_bitmanip_pkg;

    // ************************************************************
    // opcode and function codes
    // ************************************************************
    localparam logic [6:0] RVB_OPC_OP     = 7'b0110011;
    localparam logic [6:0] RVB_OPC_OP_IMM = 7'b0010011;
    localparam logic [2:0] RVB_F3_SR      = 3'b101;     // right shift slot
    localparam logic [2:0] RVB_F3_SL      = 3'b001;     // left shift slot
    localparam logic [6:0] RVB_F7_GREV    = 7'b0110100;
    localparam logic [6:0] RVB_F7_ROT     = 7'b0110000; // ror and rol
    localparam logic [5:0] RVB_F6_GREVI   = 6'b011010;
    localparam logic [5:0] RVB_F6_RORI    = 6'b011000;

    // ************************************************************
    // instruction word views
    // ************************************************************
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvb_rtype_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic [5:0] shamt6;     // rv32 uses the low five bits
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvb_shift_t;

    // register and immediate forms share one word
    typedef union packed {
        rvb_rtype_t r;
        rvb_shift_t i;
    } rvb_insn_u;

    // one retired instruction as seen on the trace port
    typedef struct packed {
        rvb_insn_u   insn;
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        logic        trap;
    } rvb_record_t;

    typedef struct packed {
        logic                       checked;  // instruction was recognized
        logic                       pass;
        logic [`RVB_MISMATCH_W-1:0] mismatch;
        logic [31:0]                pc;
    } rvb_verdict_t;

    // bit positions inside the mismatch mask
    typedef enum logic [2:0] {
        RVB_F_TRAP     = 3'd0,
        RVB_F_RS1_ADDR = 3'd1,
        RVB_F_RS2_ADDR = 3'd2,
        RVB_F_RD_ADDR  = 3'd3,
        RVB_F_RD_WDATA = 3'd4,
        RVB_F_PC_WDATA = 3'd5
    } rvb_field_e;

endpackage

`default_nettype wire

// File: rvfi_bitmanip_if.sv
`default_nettype none

// one valid/ready link, carries a record on the way in and a verdict on the way out
interface rvfi_bitmanip_if import rvfi_bitmanip_pkg::*; ();

    logic         valid;
    logic         ready;
    rvb_record_t  rec;      // dispatcher to lane
    rvb_verdict_t verdict;  // lane to collector

    // producer side of the link
    modport src (
        output valid,
        output rec,
        output verdict,
        input  ready
    );

    // consumer side of the link
    modport dst (
        input  valid,
        input  rec,
        input  verdict,
        output ready
    );

endinterface

`default_nettype wire

// File: rvfi_dispatch.sv
`default_nettype none

`include "rvfi_bitmanip_macros.svh"

module rvfi_dispatch import rvfi_bitmanip_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        rvfi_valid,
    input  wire rvb_record_t rec,
    output logic             rvfi_ready,
    rvfi_bitmanip_if.src     lane_in [`RVB_NUM_LANES]
);

    logic [`RVB_LANE_W-1:0]   turn;        // lane that gets the next beat
    logic [`RVB_NUM_LANES-1:0] lane_ready;

    // ************************************************************
    // steering
    // ************************************************************
    for (genvar i = 0; i < `RVB_NUM_LANES; i++) begin : g_lane
        assign lane_in[i].valid   = rvfi_valid && (turn == `RVB_LANE_W'(i));
        assign lane_in[i].rec     = rec;       // broadcast, valid picks the lane
        assign lane_in[i].verdict = '0;        // no verdict on the input side
        assign lane_ready[i]      = lane_in[i].ready;
    end

    // trace port sees only the lane whose turn it is
    assign rvfi_ready = lane_ready[turn];

    // ************************************************************
    // turn pointer
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            turn <= '0;
        end else if (rvfi_valid && rvfi_ready) begin
            turn <= turn + 1'b1;   // wraps, lane count is a power of two
        end
    end

endmodule

`default_nettype wire

// File: bitmanip_spec_lane.sv
`default_nettype none

`include "rvfi_bitmanip_macros.svh"

module bitmanip_spec_lane import rvfi_bitmanip_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    rvfi_bitmanip_if.dst in_if,
    rvfi_bitmanip_if.src out_if
);

    // generalized reverse, one butterfly stage per control bit
    function automatic logic [31:0] grev32(input logic [31:0] a, input logic [4:0] ctrl);
        logic [31:0] x;
        x = a;
        if (ctrl[0]) x = ((x & 32'h5555_5555) << 1)  | ((x & 32'hAAAA_AAAA) >> 1);
        if (ctrl[1]) x = ((x & 32'h3333_3333) << 2)  | ((x & 32'hCCCC_CCCC) >> 2);
        if (ctrl[2]) x = ((x & 32'h0F0F_0F0F) << 4)  | ((x & 32'hF0F0_F0F0) >> 4);
        if (ctrl[3]) x = ((x & 32'h00FF_00FF) << 8)  | ((x & 32'hFF00_FF00) >> 8);
        if (ctrl[4]) x = ((x & 32'h0000_FFFF) << 16) | ((x & 32'hFFFF_0000) >> 16);
        return x;
    endfunction

    function automatic logic [31:0] ror32(input logic [31:0] a, input logic [4:0] n);
        logic [63:0] dbl;
        dbl = {a, a} >> n;
        return dbl[31:0];
    endfunction

    function automatic logic [31:0] rol32(input logic [31:0] a, input logic [4:0] n);
        logic [63:0] dbl;
        dbl = {a, a} << n;
        return dbl[63:32];
    endfunction

    rvb_record_t                r;
    rvb_insn_u                  insn;
    logic                       dec_grev;
    logic                       dec_grevi;
    logic                       dec_ror;
    logic                       dec_rol;
    logic                       dec_rori;
    logic                       is_imm;
    logic                       known;
    logic [4:0]                 ctrl;
    logic [31:0]                result;
    logic [4:0]                 spec_rs2_addr;
    logic [31:0]                spec_rd_wdata;
    logic [31:0]                spec_pc_wdata;
    logic [`RVB_MISMATCH_W-1:0] mis;
    rvb_verdict_t               verdict_d;
    logic                       slot_full;
    rvb_verdict_t               slot_verdict;
    logic                       accept;

    assign r    = in_if.rec;
    assign insn = r.insn;

    // ************************************************************
    // decode
    // ************************************************************
    assign dec_grev  = insn.r.opcode == RVB_OPC_OP && insn.r.funct3 == RVB_F3_SR
                    && insn.r.funct7 == RVB_F7_GREV;
    assign dec_ror   = insn.r.opcode == RVB_OPC_OP && insn.r.funct3 == RVB_F3_SR
                    && insn.r.funct7 == RVB_F7_ROT;
    assign dec_rol   = insn.r.opcode == RVB_OPC_OP && insn.r.funct3 == RVB_F3_SL
                    && insn.r.funct7 == RVB_F7_ROT;
    assign dec_grevi = insn.i.opcode == RVB_OPC_OP_IMM && insn.i.funct3 == RVB_F3_SR
                    && insn.i.funct6 == RVB_F6_GREVI;
    assign dec_rori  = insn.i.opcode == RVB_OPC_OP_IMM && insn.i.funct3 == RVB_F3_SR
                    && insn.i.funct6 == RVB_F6_RORI;

    assign is_imm = dec_grevi || dec_rori;
    assign known  = dec_grev || dec_grevi || dec_ror || dec_rol || dec_rori;

    // shamt for immediate forms, rs2 value otherwise
    assign ctrl = is_imm ? insn.i.shamt6[4:0] : r.rs2_rdata[4:0];

    // ************************************************************
    // spec values
    // ************************************************************
    always_comb begin
        if (dec_grev || dec_grevi) begin
            result = grev32(r.rs1_rdata, ctrl);
        end else if (dec_rol) begin
            result = rol32(r.rs1_rdata, ctrl);
        end else begin
            result = ror32(r.rs1_rdata, ctrl);   // ror and rori
        end
    end

    assign spec_rs2_addr = is_imm ? 5'd0 : insn.r.rs2;
    assign spec_rd_wdata = (insn.r.rd != 5'd0) ? result : 32'd0;  // x0 stays zero
    assign spec_pc_wdata = r.pc_rdata + 32'd4;

    // field by field compare against the trace
    always_comb begin
        mis                 = '0;
        mis[RVB_F_TRAP]     = r.trap != 1'b0;
        mis[RVB_F_RS1_ADDR] = r.rs1_addr != insn.r.rs1;
        mis[RVB_F_RS2_ADDR] = r.rs2_addr != spec_rs2_addr;
        mis[RVB_F_RD_ADDR]  = r.rd_addr != insn.r.rd;
        mis[RVB_F_RD_WDATA] = r.rd_wdata != spec_rd_wdata;
        mis[RVB_F_PC_WDATA] = r.pc_wdata != spec_pc_wdata;
    end

    // unknown instructions pass unchecked
    assign verdict_d.checked  = known;
    assign verdict_d.pass     = !known || (mis == '0);
    assign verdict_d.mismatch = known ? mis : '0;
    assign verdict_d.pc       = r.pc_rdata;

    // ************************************************************
    // one entry slot
    // ************************************************************
    assign in_if.ready = !slot_full || out_if.ready;   // empty or draining now
    assign accept      = in_if.valid && in_if.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full <= 1'b0;
        end else if (accept) begin
            slot_full <= 1'b1;
        end else if (out_if.ready) begin
            slot_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_verdict <= verdict_d;
        end
    end

    assign out_if.valid   = slot_full;
    assign out_if.verdict = slot_verdict;
    assign out_if.rec     = '0;   // record ends at the lane

endmodule

`default_nettype wire

// File: rvfi_collect.sv
`default_nettype none

`include "rvfi_bitmanip_macros.svh"

module rvfi_collect import rvfi_bitmanip_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    rvfi_bitmanip_if.dst              lane_out [`RVB_NUM_LANES],
    output logic                      report_valid,
    output logic                      report_checked,
    output logic                      report_pass,
    output logic [`RVB_MISMATCH_W-1:0] report_mismatch,
    output logic [31:0]               report_pc,
    input  wire logic                 report_ready
);

    logic [`RVB_LANE_W-1:0]    turn;       // same order as the dispatcher
    logic [`RVB_NUM_LANES-1:0] lane_valid;
    rvb_verdict_t              lane_verdict [`RVB_NUM_LANES];
    logic                      out_full;
    rvb_verdict_t              out_q;
    logic                      can_load;
    logic                      take;

    // output register empty or leaving this cycle
    assign can_load = !out_full || report_ready;

    for (genvar i = 0; i < `RVB_NUM_LANES; i++) begin : g_lane
        assign lane_out[i].ready = can_load && (turn == `RVB_LANE_W'(i));
        assign lane_valid[i]     = lane_out[i].valid;
        assign lane_verdict[i]   = lane_out[i].verdict;
    end

    assign take = lane_valid[turn] && can_load;

    // ************************************************************
    // turn pointer and report register
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            turn     <= '0;
            out_full <= 1'b0;
        end else if (take) begin
            turn     <= turn + 1'b1;
            out_full <= 1'b1;
        end else if (report_ready) begin
            out_full <= 1'b0;
        end
    end

    // held while the sink stalls
    always_ff @(posedge clk) begin
        if (take) begin
            out_q <= lane_verdict[turn];
        end
    end

    assign report_valid    = out_full;
    assign report_checked  = out_q.checked;
    assign report_pass     = out_q.pass;
    assign report_mismatch = out_q.mismatch;
    assign report_pc       = out_q.pc;

endmodule

`default_nettype wire

// File: rvfi_bitmanip_monitor.sv
`default_nettype none

`include "rvfi_bitmanip_macros.svh"

module rvfi_bitmanip_monitor import rvfi_bitmanip_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // trace port
    input  wire logic                  rvfi_valid,
    input  wire logic [31:0]           rvfi_insn,
    input  wire logic [31:0]           rvfi_pc_rdata,
    input  wire logic [31:0]           rvfi_pc_wdata,
    input  wire logic [4:0]            rvfi_rs1_addr,
    input  wire logic [4:0]            rvfi_rs2_addr,
    input  wire logic [31:0]           rvfi_rs1_rdata,
    input  wire logic [31:0]           rvfi_rs2_rdata,
    input  wire logic [4:0]            rvfi_rd_addr,
    input  wire logic [31:0]           rvfi_rd_wdata,
    input  wire logic                  rvfi_trap,
    output logic                       rvfi_ready,

    // report port
    output logic                       report_valid,
    output logic                       report_checked,
    output logic                       report_pass,
    output logic [`RVB_MISMATCH_W-1:0] report_mismatch,
    output logic [31:0]                report_pc,
    input  wire logic                  report_ready
);

    rvb_record_t rec;

    // pack the trace beat
    assign rec.insn      = rvfi_insn;
    assign rec.pc_rdata  = rvfi_pc_rdata;
    assign rec.pc_wdata  = rvfi_pc_wdata;
    assign rec.rs1_addr  = rvfi_rs1_addr;
    assign rec.rs2_addr  = rvfi_rs2_addr;
    assign rec.rs1_rdata = rvfi_rs1_rdata;
    assign rec.rs2_rdata = rvfi_rs2_rdata;
    assign rec.rd_addr   = rvfi_rd_addr;
    assign rec.rd_wdata  = rvfi_rd_wdata;
    assign rec.trap      = rvfi_trap;

    rvfi_bitmanip_if lane_in  [`RVB_NUM_LANES] ();
    rvfi_bitmanip_if lane_out [`RVB_NUM_LANES] ();

    // ************************************************************
    // dispatcher, lanes, collector
    // ************************************************************
    rvfi_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .rvfi_valid (rvfi_valid),
        .rec        (rec),
        .rvfi_ready (rvfi_ready),
        .lane_in    (lane_in)
    );

    for (genvar i = 0; i < `RVB_NUM_LANES; i++) begin : g_lane
        bitmanip_spec_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .in_if  (lane_in[i]),
            .out_if (lane_out[i])
        );
    end

    rvfi_collect u_collect (
        .clk             (clk),
        .rst_n           (rst_n),
        .lane_out        (lane_out),
        .report_valid    (report_valid),
        .report_checked  (report_checked),
        .report_pass     (report_pass),
        .report_mismatch (report_mismatch),
        .report_pc       (report_pc),
        .report_ready    (report_ready)
    );

endmodule

`default_nettype wire

// File: tb_rvfi_bitmanip_monitor.sv
`default_nettype none

`include "rvfi_bitmanip_macros.svh"

module tb_rvfi_bitmanip_monitor import rvfi_bitmanip_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int N_TOTAL    = 160 + 10 + 68 + 16 + 150;   // all phases
    localparam int NUM_MAX    = 512;
    localparam int OP_GREV    = 0;
    localparam int OP_GREVI   = 1;
    localparam int OP_ROR     = 2;
    localparam int OP_ROL     = 3;
    localparam int OP_RORI    = 4;
    localparam int OP_NONE    = -1;
    localparam int K_RD       = 1;   // corruption kinds on top of a clean kind 0
    localparam int K_PC       = 2;
    localparam int K_TRAP     = 3;
    localparam int K_RS2      = 4;
    localparam int K_UNKNOWN  = 5;

    typedef struct packed {
        logic                       timed;      // latency is checked for this one
        logic                       checked;
        logic                       pass;
        logic [`RVB_MISMATCH_W-1:0] mismatch;
        logic [31:0]                pc;
        logic [31:0]                acc_cycle;  // edge of the rvfi handshake
    } exp_t;

    logic                       clk;
    logic                       rst_n;
    logic                       rvfi_valid;
    logic [31:0]                rvfi_insn;
    logic [31:0]                rvfi_pc_rdata;
    logic [31:0]                rvfi_pc_wdata;
    logic [4:0]                 rvfi_rs1_addr;
    logic [4:0]                 rvfi_rs2_addr;
    logic [31:0]                rvfi_rs1_rdata;
    logic [31:0]                rvfi_rs2_rdata;
    logic [4:0]                 rvfi_rd_addr;
    logic [31:0]                rvfi_rd_wdata;
    logic                       rvfi_trap;
    logic                       rvfi_ready;
    logic                       report_valid;
    logic                       report_checked;
    logic                       report_pass;
    logic [`RVB_MISMATCH_W-1:0] report_mismatch;
    logic [31:0]                report_pc;
    logic                       report_ready;

    integer      seed = 32'h9b9f;
    exp_t        exp_mem [NUM_MAX];   // expected verdicts in acceptance order
    exp_t        head;
    int          wr_idx = 0;
    int          rd_idx;
    logic [31:0] cyc = '0;
    logic [31:0] pc_next = 32'h0000_1000;
    logic        rand_ready = 1'b0;
    logic        xfer;

    rvfi_bitmanip_monitor dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx <= 0;
        end else if (xfer) begin
            rd_idx <= rd_idx + 1;   // head moves on each report
        end
    end

    assign xfer = report_valid && report_ready;
    assign head = exp_mem[rd_idx];

    task automatic wrong_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("** FAIL **");
        $fatal(1, "value check failed");
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    // ************************************************************
    // reference model of the lane rules
    // ************************************************************
    function automatic logic [31:0] spec_value(input int op, input logic [31:0] a,
                                               input logic [4:0] n);
        logic [31:0] y;
        logic [4:0]  j;
        y = '0;
        if (op == OP_GREV || op == OP_GREVI) begin
            for (int i = 0; i < 32; i++) begin
                j    = 5'(i) ^ n;   // bit i of grev comes from bit i xor ctrl
                y[i] = a[j];
            end
        end else if (op == OP_ROL) begin
            y = (a << n) | (a >> (32 - n));
        end else begin
            y = (a >> n) | (a << (32 - n));
        end
        return y;
    endfunction

    function automatic int decode_op(input logic [31:0] w);
        if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0110100 && w[14:12] == 3'b101) return OP_GREV;
        if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0110000 && w[14:12] == 3'b101) return OP_ROR;
        if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0110000 && w[14:12] == 3'b001) return OP_ROL;
        if (w[6:0] == 7'b0010011 && w[31:26] == 6'b011010 && w[14:12] == 3'b101) return OP_GREVI;
        if (w[6:0] == 7'b0010011 && w[31:26] == 6'b011000 && w[14:12] == 3'b101) return OP_RORI;
        return OP_NONE;
    endfunction

    function automatic exp_t expect_verdict(input rvb_record_t rec);
        exp_t                       e;
        logic [31:0]                w;
        logic [31:0]                val;
        logic [4:0]                 ctrl;
        logic [`RVB_MISMATCH_W-1:0] m;
        int                         op;
        logic                       is_imm;
        w      = rec.insn;
        op     = decode_op(w);
        e      = '0;
        e.pc   = rec.pc_rdata;
        e.pass = 1'b1;
        if (op == OP_NONE) return e;   // unchecked and passing
        is_imm = (op == OP_GREVI || op == OP_RORI);
        ctrl   = is_imm ? w[24:20] : rec.rs2_rdata[4:0];
        val    = (w[11:7] == 5'd0) ? 32'd0 : spec_value(op, rec.rs1_rdata, ctrl);
        m                 = '0;
        m[RVB_F_TRAP]     = rec.trap;
        m[RVB_F_RS1_ADDR] = rec.rs1_addr != w[19:15];
        m[RVB_F_RS2_ADDR] = rec.rs2_addr != (is_imm ? 5'd0 : w[24:20]);
        m[RVB_F_RD_ADDR]  = rec.rd_addr != w[11:7];
        m[RVB_F_RD_WDATA] = rec.rd_wdata != val;
        m[RVB_F_PC_WDATA] = rec.pc_wdata != rec.pc_rdata + 32'd4;
        e.checked  = 1'b1;
        e.pass     = (m == '0);
        e.mismatch = m;
        return e;
    endfunction

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic make_trace(input int op, input logic [4:0] ctrl, output rvb_record_t rec);
        logic [31:0] r;
        logic [4:0]  rd;
        r   = $random(seed);
        rd  = r[14:10];
        rec = '0;
        if (op == OP_GREVI || op == OP_RORI) begin
            rec.insn = {(op == OP_GREVI) ? 6'b011010 : 6'b011000, 1'b0, ctrl,
                        r[4:0], 3'b101, rd, 7'b0010011};
        end else begin
            rec.insn = {(op == OP_GREV) ? 7'b0110100 : 7'b0110000, r[9:5], r[4:0],
                        (op == OP_ROL) ? 3'b001 : 3'b101, rd, 7'b0110011};
            rec.rs2_addr = r[9:5];
        end
        rec.rs1_addr       = r[4:0];
        rec.rd_addr        = rd;
        rec.rs1_rdata      = $random(seed);
        rec.rs2_rdata      = $random(seed);
        rec.rs2_rdata[4:0] = ctrl;
        rec.pc_rdata       = pc_next;
        rec.pc_wdata       = pc_next + 32'd4;
        rec.rd_wdata       = (rd == 5'd0) ? 32'd0 : spec_value(op, rec.rs1_rdata, ctrl);
        pc_next            = pc_next + 32'd4;
    endtask

    task automatic corrupt(inout rvb_record_t rec, input int kind);
        logic [31:0] r;
        logic [31:0] w;
        r = $random(seed);
        w = rec.insn;
        case (kind)
            K_RD:      rec.rd_wdata = rec.rd_wdata ^ (32'd1 << r[4:0]);
            K_PC:      rec.pc_wdata = rec.pc_rdata + 32'd8;
            K_TRAP:    rec.trap = 1'b1;
            K_RS2:     rec.rs2_addr = r[4:0] | 5'd1;
            K_UNKNOWN: rec.insn = r[0] ? {7'b0000000, w[24:15], 3'b000, w[11:7], 7'b0110011}
                                       : {7'b0110100, w[24:15], 3'b001, w[11:7], 7'b0110011};
            default: ;
        endcase
    endtask

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r            = $random(seed);
        report_ready = rand_ready ? r[0] : 1'b1;
    endtask

    // beat held until the handshake with ready sampled mid cycle
    task automatic send(input rvb_record_t rec, input logic timed);
        exp_t e;
        logic ok;
        e              = expect_verdict(rec);
        e.timed        = timed;
        rvfi_insn      = rec.insn;
        rvfi_pc_rdata  = rec.pc_rdata;
        rvfi_pc_wdata  = rec.pc_wdata;
        rvfi_rs1_addr  = rec.rs1_addr;
        rvfi_rs2_addr  = rec.rs2_addr;
        rvfi_rs1_rdata = rec.rs1_rdata;
        rvfi_rs2_rdata = rec.rs2_rdata;
        rvfi_rd_addr   = rec.rd_addr;
        rvfi_rd_wdata  = rec.rd_wdata;
        rvfi_trap      = rec.trap;
        rvfi_valid     = 1'b1;
        ok             = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = rvfi_ready;
            if (ok) begin
                e.acc_cycle     = cyc;
                exp_mem[wr_idx] = e;
                wr_idx          = wr_idx + 1;
            end
            next_cycle();
        end
        rvfi_valid = 1'b0;
    endtask

    task automatic drain();
        while (rd_idx != wr_idx) next_cycle();
    endtask

    // ************************************************************
    // checks
    // ************************************************************
    a_checked: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> report_checked == head.checked)
        else wrong_value("report_checked", $sampled(report_checked), $sampled(head.checked));
    a_pass: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> report_pass == head.pass)
        else wrong_value("report_pass", $sampled(report_pass), $sampled(head.pass));
    a_mismatch: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> report_mismatch == head.mismatch)
        else wrong_value("report_mismatch", $sampled(report_mismatch), $sampled(head.mismatch));
    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> report_pc == head.pc)
        else wrong_value("report_pc", $sampled(report_pc), $sampled(head.pc));
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && head.timed) |-> cyc == head.acc_cycle + 32'd2)
        else wrong_value("report_valid cycle", $sampled(cyc), $sampled(head.acc_cycle) + 2);
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (report_valid && !report_ready) |=> (report_valid && $stable(report_checked)
            && $stable(report_pass) && $stable(report_mismatch) && $stable(report_pc)))
        else abort_run("report dropped or changed while the sink stalled");
    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        report_valid |-> rd_idx < wr_idx)
        else abort_run("report arrived with no instruction outstanding");

    initial begin : watchdog
        #((40 * N_TOTAL + 200) * CLK_PERIOD);
        abort_run("watchdog expired before all reports arrived");
    end

    initial begin : main
        rvb_record_t rec;
        logic [31:0] r;
        int          op;
        rst_n          = 1'b0;
        rvfi_valid     = 1'b0;
        rvfi_insn      = '0;
        rvfi_pc_rdata  = '0;
        rvfi_pc_wdata  = '0;
        rvfi_rs1_addr  = '0;
        rvfi_rs2_addr  = '0;
        rvfi_rs1_rdata = '0;
        rvfi_rs2_rdata = '0;
        rvfi_rd_addr   = '0;
        rvfi_rd_wdata  = '0;
        rvfi_trap      = 1'b0;
        report_ready   = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        a_rst_valid: assert (!report_valid)
            else wrong_value("report_valid", report_valid, 32'd0);
        a_rst_ready: assert (rvfi_ready)
            else wrong_value("rvfi_ready", rvfi_ready, 32'd1);
        next_cycle();

        // every control value on correct back to back traces
        for (int k = 0; k < 32; k++) begin
            for (op = 0; op < 5; op++) begin
                make_trace(op, 5'(k), rec);
                send(rec, 1'b1);
            end
        end

        // x0 destination takes only a zero write value
        for (op = 0; op < 5; op++) begin
            for (int bad = 0; bad < 2; bad++) begin
                make_trace(op, 5'(op + 7), rec);
                rec.insn.r.rd = 5'd0;
                rec.rd_addr   = 5'd0;
                rec.rd_wdata  = (bad != 0) ? (rec.rs1_rdata | 32'd1) : 32'd0;
                send(rec, 1'b1);
            end
        end

        // corrupted traces
        for (int n = 0; n < 4; n++) begin
            for (op = 0; op < 5; op++) begin
                for (int kind = K_RD; kind <= K_TRAP; kind++) begin
                    r = $random(seed);
                    make_trace(op, r[4:0], rec);
                    corrupt(rec, kind);
                    send(rec, 1'b1);
                end
            end
        end
        for (int n = 0; n < 8; n++) begin
            make_trace(OP_GREVI, 5'(n * 3), rec);
            corrupt(rec, K_RS2);
            send(rec, 1'b1);
        end

        // add and misencoded grev
        for (int n = 0; n < 16; n++) begin
            make_trace(n % 5, 5'(n), rec);
            corrupt(rec, K_UNKNOWN);
            send(rec, 1'b1);
        end
        drain();

        // random mix with a stalling sink
        rand_ready = 1'b1;
        for (int n = 0; n < 150; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) next_cycle();   // gap on the trace port
            make_trace(int'(r[10:2] % 5), r[15:11], rec);
            corrupt(rec, int'(r[24:16] % 6));
            send(rec, 1'b0);
        end
        drain();
        rand_ready = 1'b0;
        repeat (10) next_cycle();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: rvfi_bitmanip_monitor.f
+incdir+.
rvfi_bitmanip_pkg.sv
rvfi_bitmanip_if.sv
rvfi_dispatch.sv
bitmanip_spec_lane.sv
rvfi_collect.sv
rvfi_bitmanip_monitor.sv
tb_rvfi_bitmanip_monitor.sv

// File: run_sim.sh
#!/bin/sh
# build the monitor testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rvfi_bitmanip_monitor \
    -f rvfi_bitmanip_monitor.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_rvfi_bitmanip_monitor)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' && echo "simulation ok" ||
    { echo "simulation not ok"; exit 1; }
